// File: vlog.f
src/clint_pkg.sv
src/clint_timer.sv
src/mem_xbar.sv
src/scratch_ram.sv
src/timer_subsys_top.sv
verif/timer_subsys_checker.sv
verif/timer_subsys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the timer subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=Vtimer_subsys_tb

verilator --binary --timing --assert -sv -f vlog.f \
    --top-module timer_subsys_tb -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: PASS" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// File: verif/timer_subsys_tb.sv
// Testbench for the timer subsystem
// Table-driven requests under credit flow control, plus interrupt checks
`timescale 1ns/1ps

module timer_subsys_tb;

    import clint_pkg::*;

    localparam int RAM_WORDS = 256;
    localparam int CREDITS   = 2;
    localparam int TIMEOUT   = 50;

    // Check modes of a table entry
    localparam logic [1:0] MODE_EXACT = 2'd0;
    localparam logic [1:0] MODE_RANGE = 2'd1;
    localparam logic [1:0] MODE_MTIME = 2'd2;

    localparam logic [31:0] MSIP_ADDR  = CLINT_BASE | {16'h0, MSIP_OFFSET};
    localparam logic [31:0] CMP_ADDR   = CLINT_BASE | {16'h0, MTIMECMP_OFFSET};
    localparam logic [31:0] MTIME_ADDR = CLINT_BASE | {16'h0, MTIME_OFFSET};
    localparam logic [63:0] MTIME_X    = 64'h0000_0001_0000_0000;
    localparam logic [63:0] FAR_CMP    = 64'h0fff_0000_0000_0000;

    // One request with its expected response
    typedef struct packed {
        logic        wen;
        logic [31:0] addr;
        logic [63:0] wdata;
        logic [63:0] exp_lo;
        logic [63:0] exp_hi;
        logic        exp_err;
        logic [1:0]  mode;
        logic [7:0]  gap;
        logic [31:0] sent_cyc;
    } entry_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        req_valid;
    mem_req_t    req;
    logic        rsp_valid;
    mem_rsp_t    rsp;
    logic        credit_return;
    logic        timer_irq;
    logic        soft_irq;

    entry_t      stim_table[$];
    entry_t      inflight_q[$];
    logic [63:0] ram_word[4];
    int          ram_idx[4] = '{0, 5, 77, RAM_WORDS - 1};
    int          cyc = 0;
    int          sent = 0;
    int          returned = 0;
    int          rsp_count = 0;
    // Credit pulse seen on the last falling edge, not yet taken
    logic        return_pending = 1'b0;
    // Last mtime write, reference for exact mtime reads
    logic [63:0] mtime_ref_val = 64'd0;
    int          mtime_ref_cyc = 0;

    timer_subsys_top #(
        .RAM_WORDS(RAM_WORDS),
        .CREDITS  (CREDITS)
    ) DUT (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req          (req),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .credit_return(credit_return),
        .timer_irq    (timer_irq),
        .soft_irq     (soft_irq)
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------
    // Checks and failure reporting
    // ------------------------------------------------------------

    task automatic report_failure(input string msg);
        $display("Failure at %0t ns: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "testbench stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR: time %0t signal %s actual 0x%0h expected 0x%0h",
                     $time, name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic int credits_held();
        return CREDITS - sent + returned;
    endfunction

    function automatic logic [31:0] ram_addr(input int idx);
        return RAM_BASE + 32'(idx) * 32'd8;
    endfunction

    // ------------------------------------------------------------
    // Requester
    // ------------------------------------------------------------

    // One falling edge: collect outputs first, then release the request
    task automatic tick();
        entry_t e;
        logic   in_range;
        @(negedge clk);
        cyc++;
        // Pulse from last cycle was taken on the rising edge just passed
        if (return_pending) begin
            returned++;
        end
        return_pending = credit_return;
        if (rsp_valid) begin
            rsp_count++;
            if (inflight_q.size() == 0) begin
                report_failure("response arrived with no request in flight");
            end
            e = inflight_q.pop_front();
            // Accepted on the next rising edge, visible one falling edge later
            check_value("rsp latency", 64'(cyc - int'(e.sent_cyc)), 64'd1);
            check_value("rsp.err", 64'(rsp.err), 64'(e.exp_err));
            in_range = (rsp.rdata >= e.exp_lo) && (rsp.rdata <= e.exp_hi);
            if (e.mode == MODE_RANGE) begin
                check_value("rsp.rdata in range", 64'(in_range), 64'd1);
            end else begin
                check_value("rsp.rdata", rsp.rdata, e.exp_lo);
            end
        end
        req_valid = 1'b0;
    endtask

    task automatic send_req(input entry_t e);
        int waited;
        tick();
        waited = 0;
        // Hold off while every credit is out
        while (credits_held() == 0) begin
            if (waited >= TIMEOUT) begin
                report_failure("timed out waiting for a request credit");
            end
            tick();
            waited++;
        end
        // mtime read returns the value from before its accepting edge
        if (e.mode == MODE_MTIME) begin
            e.exp_lo = mtime_ref_val + 64'(cyc - mtime_ref_cyc - 1);
            e.mode   = MODE_EXACT;
        end
        if (e.wen && e.addr == MTIME_ADDR) begin
            mtime_ref_val = e.wdata;
            mtime_ref_cyc = cyc;
        end
        e.sent_cyc = 32'(cyc);
        inflight_q.push_back(e);
        sent++;
        req_valid = 1'b1;
        req.wen   = e.wen;
        req.addr  = e.addr;
        req.wdata = e.wdata;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        // Last credit is taken one edge after its pulse
        while (inflight_q.size() > 0 || return_pending) begin
            if (waited >= TIMEOUT) begin
                report_failure("timed out waiting for outstanding responses");
            end
            tick();
            waited++;
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------

    function automatic entry_t make_entry(input logic wen, input logic [31:0] addr,
                                          input logic [63:0] wdata, input logic [63:0] exp_lo,
                                          input logic exp_err, input logic [1:0] mode,
                                          input int gap);
        entry_t e;
        e.wen      = wen;
        e.addr     = addr;
        e.wdata    = wdata;
        e.exp_lo   = exp_lo;
        e.exp_hi   = exp_lo;
        e.exp_err  = exp_err;
        e.mode     = mode;
        e.gap      = 8'(gap);
        e.sent_cyc = 32'd0;
        return e;
    endfunction

    // Writes always answer with zero data
    task automatic add_write(input logic [31:0] addr, input logic [63:0] wdata,
                             input logic exp_err);
        stim_table.push_back(make_entry(1'b1, addr, wdata, 64'd0, exp_err, MODE_EXACT, 0));
    endtask

    task automatic add_read(input logic [31:0] addr, input logic [63:0] exp_lo,
                            input logic exp_err, input logic [1:0] mode, input int gap);
        stim_table.push_back(make_entry(1'b0, addr, 64'd0, exp_lo, exp_err, mode, gap));
    endtask

    task automatic write_and_drain(input logic [31:0] addr, input logic [63:0] wdata);
        send_req(make_entry(1'b1, addr, wdata, 64'd0, 1'b0, MODE_EXACT, 0));
        drain();
    endtask

    task automatic build_table();
        entry_t e;
        // RAM words, random data, then back-to-back reads
        for (int i = 0; i < 4; i++) begin
            ram_word[i] = {$urandom(), $urandom()};
            add_write(ram_addr(ram_idx[i]), ram_word[i], 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            add_read(ram_addr(ram_idx[i]), ram_word[i], 1'b0, MODE_EXACT, 0);
        end
        // mtime load, reads n cycles later
        add_write(MTIME_ADDR, MTIME_X, 1'b0);
        add_read(MTIME_ADDR, 64'd0, 1'b0, MODE_MTIME, 0);
        add_read(MTIME_ADDR, 64'd0, 1'b0, MODE_MTIME, 3);
        add_read(MTIME_ADDR, 64'd0, 1'b0, MODE_MTIME, 9);
        e = make_entry(1'b0, MTIME_ADDR, 64'd0, MTIME_X, 1'b0, MODE_RANGE, 2);
        e.exp_hi = MTIME_X + 64'd1000;
        stim_table.push_back(e);
        add_write(CMP_ADDR, 64'h1234_5678_9abc_def0, 1'b0);
        add_read(CMP_ADDR, 64'h1234_5678_9abc_def0, 1'b0, MODE_EXACT, 0);
        add_write(MSIP_ADDR, 64'd1, 1'b0);
        add_read(MSIP_ADDR, 64'd1, 1'b0, MODE_EXACT, 0);
        add_write(MSIP_ADDR, 64'd0, 1'b0);
        add_read(MSIP_ADDR, 64'd0, 1'b0, MODE_EXACT, 0);
        // Unmapped, unknown offset, misaligned and past the end of RAM
        add_read(32'h1000_0000, 64'd0, 1'b1, MODE_EXACT, 1);
        add_write(32'h4000_0000, 64'hdead_beef, 1'b1);
        add_read(CLINT_BASE | 32'h0008, 64'd0, 1'b1, MODE_EXACT, 0);
        add_write(CLINT_BASE | 32'h1000, 64'd7, 1'b1);
        add_write(ram_addr(ram_idx[1]) + 32'd4, ~ram_word[1], 1'b1);
        add_read(ram_addr(ram_idx[2]) + 32'd2, 64'd0, 1'b1, MODE_EXACT, 0);
        add_read(ram_addr(RAM_WORDS), 64'd0, 1'b1, MODE_EXACT, 0);
        // RAM untouched by the rejected accesses
        for (int i = 0; i < 4; i++) begin
            add_read(ram_addr(ram_idx[i]), ram_word[i], 1'b0, MODE_EXACT, 0);
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial begin
        int waited;
        void'($urandom(81572));
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        // Four rising edges in reset
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // mtime and mtimecmp both 0 out of reset
        check_value("timer_irq", 64'(timer_irq), 64'd1);
        check_value("soft_irq", 64'(soft_irq), 64'd0);
        check_value("rsp_valid", 64'(rsp_valid), 64'd0);

        build_table();
        for (int i = 0; i < stim_table.size(); i++) begin
            repeat (int'(stim_table[i].gap)) tick();
            send_req(stim_table[i]);
        end
        drain();
        check_value("credits held", 64'(credits_held()), 64'(CREDITS));

        // Timer interrupt drops, then returns 5 edges after the load
        write_and_drain(CMP_ADDR, FAR_CMP);
        check_value("timer_irq", 64'(timer_irq), 64'd0);
        write_and_drain(MTIME_ADDR, FAR_CMP - 64'd5);
        check_value("timer_irq", 64'(timer_irq), 64'd0);
        waited = 0;
        while (!timer_irq) begin
            if (waited >= TIMEOUT) begin
                report_failure("timed out waiting for timer_irq");
            end
            tick();
            waited++;
        end
        check_value("timer_irq delay", 64'(cyc - mtime_ref_cyc - 1), 64'd5);

        // Software interrupt follows msip bit 0
        write_and_drain(MSIP_ADDR, 64'd1);
        check_value("soft_irq", 64'(soft_irq), 64'd1);
        write_and_drain(MSIP_ADDR, 64'd0);
        check_value("soft_irq", 64'(soft_irq), 64'd0);

        // Two reads take every credit, the third waits for a return
        send_req(make_entry(1'b0, ram_addr(ram_idx[0]), 64'd0, ram_word[0], 1'b0, MODE_EXACT, 0));
        send_req(make_entry(1'b0, ram_addr(ram_idx[1]), 64'd0, ram_word[1], 1'b0, MODE_EXACT, 0));
        check_value("credits held", 64'(credits_held()), 64'd0);
        send_req(make_entry(1'b0, ram_addr(ram_idx[3]), 64'd0, ram_word[3], 1'b0, MODE_EXACT, 0));
        drain();

        check_value("credits held", 64'(credits_held()), 64'(CREDITS));
        check_value("credit returns", 64'(returned), 64'(rsp_count));
        check_value("responses", 64'(rsp_count), 64'(sent));
        // Protocol assertions in the bound checker
        if (DUT.u_checker.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verif/timer_subsys_checker.sv
// Protocol assertions on the timer subsystem outside port
// Credit return, response timing and zero data on errors
`timescale 1ns/1ps

module timer_subsys_checker (
    input logic                clk,
    input logic                reset,
    input logic                req_valid,
    input logic                rsp_valid,
    input clint_pkg::mem_rsp_t rsp,
    input logic                credit_return
);

    // Failed assertions so far, read by the testbench
    int fail_count = 0;

    // One credit per response, same cycle
    credit_matches_rsp: assert property (@(posedge clk) disable iff (reset)
        credit_return == rsp_valid)
        else begin
            $error("credit_return does not match rsp_valid");
            fail_count++;
        end

    // Every request answers on the next edge
    rsp_follows_req: assert property (@(posedge clk) disable iff (reset)
        req_valid |=> rsp_valid)
        else begin
            $error("request without a response one cycle later");
            fail_count++;
        end

    // No response without a request one cycle before
    rsp_has_req: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> $past(req_valid))
        else begin
            $error("response without a request one cycle before");
            fail_count++;
        end

    // Errors carry zero data
    err_zero_data: assert property (@(posedge clk) disable iff (reset)
        (rsp_valid && rsp.err) |-> (rsp.rdata == 64'd0))
        else begin
            $error("error response with nonzero rdata");
            fail_count++;
        end

endmodule

bind timer_subsys_top timer_subsys_checker u_checker (
    .clk          (clk),
    .reset        (reset),
    .req_valid    (req_valid),
    .rsp_valid    (rsp_valid),
    .rsp          (rsp),
    .credit_return(credit_return)
);

// File: src/timer_subsys_top.sv
// Timer subsystem top level
// Crossbar in front of the CLINT and the scratch RAM
`timescale 1ns/1ps

module timer_subsys_top #(
    parameter int RAM_WORDS = 256,
    // Credits granted to the requester after reset
    parameter int CREDITS   = 2
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    input  clint_pkg::mem_req_t req,
    output logic                rsp_valid,
    output clint_pkg::mem_rsp_t rsp,
    output logic                credit_return,
    output logic                timer_irq,
    output logic                soft_irq
);

    import clint_pkg::*;

    // ------------------------------------------------------------
    // Crossbar to target wiring
    // ------------------------------------------------------------

    logic                         clint_sel;
    logic                         ram_sel;
    logic                         tgt_wen;
    logic [15:0]                  clint_offset;
    logic [$clog2(RAM_WORDS)-1:0] ram_index;
    logic [63:0]                  tgt_wdata;

    // Target responses
    logic                         clint_rsp_valid;
    slave_rsp_t                   clint_rsp;
    logic                         ram_rsp_valid;
    slave_rsp_t                   ram_rsp;

    // Decode and merge
    mem_xbar #(
        .RAM_WORDS(RAM_WORDS)
    ) u_xbar (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req            (req),
        .clint_rsp_valid(clint_rsp_valid),
        .clint_rsp      (clint_rsp),
        .ram_rsp_valid  (ram_rsp_valid),
        .ram_rsp        (ram_rsp),
        .clint_sel      (clint_sel),
        .ram_sel        (ram_sel),
        .wen            (tgt_wen),
        .offset         (clint_offset),
        .index          (ram_index),
        .wdata          (tgt_wdata),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .credit_return  (credit_return)
    );

    // mtime, mtimecmp, msip
    clint_timer u_clint (
        .clk      (clk),
        .reset    (reset),
        .sel      (clint_sel),
        .wen      (tgt_wen),
        .offset   (clint_offset),
        .wdata    (tgt_wdata),
        .rsp_valid(clint_rsp_valid),
        .rsp      (clint_rsp),
        .timer_irq(timer_irq),
        .soft_irq (soft_irq)
    );

    // Scratch memory
    scratch_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) u_ram (
        .clk      (clk),
        .reset    (reset),
        .sel      (ram_sel),
        .wen      (tgt_wen),
        .index    (ram_index),
        .wdata    (tgt_wdata),
        .rsp_valid(ram_rsp_valid),
        .rsp      (ram_rsp)
    );

endmodule

// File: src/scratch_ram.sv
// Scratch RAM, 64-bit words, single port
// Registered read data one cycle after the select
`timescale 1ns/1ps

module scratch_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          sel,
    input  logic                          wen,
    input  logic [$clog2(RAM_WORDS)-1:0]  index,
    input  logic [63:0]                   wdata,
    output logic                          rsp_valid,
    output clint_pkg::slave_rsp_t         rsp
);

    // Storage, contents undefined after reset
    logic [63:0] mem [RAM_WORDS];

    // ------------------------------------------------------------
    // Array access
    // ------------------------------------------------------------

    // Write stores the word
    always_ff @(posedge clk) begin
        if (sel && wen) begin
            mem[index] <= wdata;
        end
    end

    // Read returns the old word, crossbar zeroes it on writes
    always_ff @(posedge clk) begin
        if (sel) begin
            rsp.rdata <= mem[index];
            rsp.hit   <= 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Response strobe
    // ------------------------------------------------------------

    // Every selected access answers next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= sel;
        end
    end

endmodule

// File: src/mem_xbar.sv
// Request decoder and response merger for the timer subsystem
// Routes to CLINT or RAM, answers unmapped requests with err, returns credits
`timescale 1ns/1ps

module mem_xbar #(
    parameter int RAM_WORDS = 256
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           req_valid,
    input  clint_pkg::mem_req_t            req,
    input  logic                           clint_rsp_valid,
    input  clint_pkg::slave_rsp_t          clint_rsp,
    input  logic                           ram_rsp_valid,
    input  clint_pkg::slave_rsp_t          ram_rsp,
    output logic                           clint_sel,
    output logic                           ram_sel,
    output logic                           wen,
    output logic [15:0]                    offset,
    output logic [$clog2(RAM_WORDS)-1:0]   index,
    output logic [63:0]                    wdata,
    output logic                           rsp_valid,
    output clint_pkg::mem_rsp_t            rsp,
    output logic                           credit_return
);

    import clint_pkg::*;

    localparam int          IDX_W     = $clog2(RAM_WORDS);
    localparam logic [31:0] RAM_BYTES = 32'(RAM_WORDS) * 32'd8;

    // Region decode
    logic        clint_hit;
    logic        ram_hit;
    logic [31:0] ram_off;

    // State for the response slot
    logic        err_q;
    logic        wen_q;

    // Merged target response
    logic        tgt_valid;
    logic        tgt_hit;
    logic [63:0] tgt_rdata;
    logic        rsp_err;

    // ------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------

    // CLINT, 64 KiB aligned window
    assign clint_hit = ((req.addr & ~(CLINT_SIZE - 32'd1)) == CLINT_BASE);

    // RAM, in range and word aligned
    assign ram_off = req.addr - RAM_BASE;
    assign ram_hit = (req.addr >= RAM_BASE) && (ram_off < RAM_BYTES) &&
                     (req.addr[2:0] == 3'b000);

    // At most one select per request
    assign clint_sel = req_valid && clint_hit;
    assign ram_sel   = req_valid && ram_hit;

    // Shared fields to both targets
    assign wen    = req.wen;
    assign offset = req.addr[15:0];
    assign index  = ram_off[IDX_W+2:3];
    assign wdata  = req.wdata;

    // ------------------------------------------------------------
    // Error slot
    // ------------------------------------------------------------

    // Unmapped request answers in the same one-cycle slot as a target
    always_ff @(posedge clk) begin
        if (reset) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req_valid && !clint_hit && !ram_hit;
        end
    end

    // Remember writes so read data can be zeroed
    always_ff @(posedge clk) begin
        if (req_valid) begin
            wen_q <= req.wen;
        end
    end

    // ------------------------------------------------------------
    // Response merge
    // ------------------------------------------------------------

    // Targets are one-hot, pick whichever answered
    always_comb begin
        tgt_valid = clint_rsp_valid || ram_rsp_valid;
        tgt_hit   = 1'b0;
        tgt_rdata = 64'd0;
        if (clint_rsp_valid) begin
            tgt_hit   = clint_rsp.hit;
            tgt_rdata = clint_rsp.rdata;
        end else if (ram_rsp_valid) begin
            tgt_hit   = ram_rsp.hit;
            tgt_rdata = ram_rsp.rdata;
        end
    end

    // Decode miss or target miss
    assign rsp_err = err_q || (tgt_valid && !tgt_hit);

    assign rsp_valid = tgt_valid || err_q;

    // Writes and errors carry zero data
    always_comb begin
        rsp.err   = rsp_err;
        rsp.rdata = (wen_q || rsp_err) ? 64'd0 : tgt_rdata;
    end

    // One credit back per response, no buffering here
    assign credit_return = rsp_valid;

endmodule

// File: src/clint_timer.sv
// Core-local interruptor for one hart
// Holds mtime, mtimecmp and msip, drives timer and software interrupt levels
`timescale 1ns/1ps

module clint_timer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  sel,
    input  logic                  wen,
    input  logic [15:0]           offset,
    input  logic [63:0]           wdata,
    output logic                  rsp_valid,
    output clint_pkg::slave_rsp_t rsp,
    output logic                  timer_irq,
    output logic                  soft_irq
);

    import clint_pkg::*;

    // Architectural state
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        msip;

    // Write strobes per register
    logic        mtime_wr;
    logic        mtimecmp_wr;
    logic        msip_wr;

    // Combinational read mux
    logic [63:0] rd_val;
    logic        rd_hit;

    // ------------------------------------------------------------
    // Write decode
    // ------------------------------------------------------------

    // Offset only, the crossbar already checked the region
    assign mtime_wr    = sel && wen && (offset == MTIME_OFFSET);
    assign mtimecmp_wr = sel && wen && (offset == MTIMECMP_OFFSET);
    assign msip_wr     = sel && wen && (offset == MSIP_OFFSET);

    // ------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------

    // Counts every cycle; a write loads the value instead of the increment
    always_ff @(posedge clk) begin
        if (reset) begin
            mtime <= 64'd0;
        end else if (mtime_wr) begin
            mtime <= wdata;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mtimecmp <= 64'd0;
        end else if (mtimecmp_wr) begin
            mtimecmp <= wdata;
        end
    end

    // Only bit 0 of msip is implemented
    always_ff @(posedge clk) begin
        if (reset) begin
            msip <= 1'b0;
        end else if (msip_wr) begin
            msip <= wdata[0];
        end
    end

    // ------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------

    // Value before this edge is what gets returned
    always_comb begin
        rd_val = 64'd0;
        rd_hit = 1'b1;
        case (offset)
            MSIP_OFFSET:     rd_val = {63'd0, msip};
            MTIMECMP_OFFSET: rd_val = mtimecmp;
            MTIME_OFFSET:    rd_val = mtime;
            default: begin
                // Unknown offset, crossbar turns this into err
                rd_hit = 1'b0;
            end
        endcase
    end

    // One-cycle response strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= sel;
        end
    end

    // Response payload, only meaningful with rsp_valid
    always_ff @(posedge clk) begin
        if (sel) begin
            rsp.rdata <= wen ? 64'd0 : rd_val;
            rsp.hit   <= rd_hit;
        end
    end

    // ------------------------------------------------------------
    // Interrupt levels
    // ------------------------------------------------------------

    // Level high while mtime has reached the compare value
    assign timer_irq = (mtime >= mtimecmp);

    // msip is already a flop
    assign soft_irq = msip;

endmodule

// File: src/clint_pkg.sv
// Shared definitions for the machine-mode timer subsystem
// Address map, CLINT offsets and the request/response structs

package clint_pkg;

    // ------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------

    // CLINT region, 64 KiB aligned
    localparam logic [31:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [31:0] CLINT_SIZE = 32'h0001_0000;

    // Scratch RAM base, size set by RAM_WORDS at the top level
    localparam logic [31:0] RAM_BASE = 32'h8000_0000;

    // ------------------------------------------------------------
    // CLINT register offsets inside the region
    // ------------------------------------------------------------

    // Software interrupt pending, bit 0 only
    localparam logic [15:0] MSIP_OFFSET = 16'h0000;
    // Timer compare value, hart 0
    localparam logic [15:0] MTIMECMP_OFFSET = 16'h4000;
    // Free running machine time
    localparam logic [15:0] MTIME_OFFSET = 16'hBFF8;

    // ------------------------------------------------------------
    // Request and response payloads
    // ------------------------------------------------------------

    // Request from the core side, full 64-bit access
    typedef struct packed {
        logic        wen;
        logic [31:0] addr;
        logic [63:0] wdata;
    } mem_req_t;

    // Response back to the core side
    typedef struct packed {
        logic [63:0] rdata;
        logic        err;
    } mem_rsp_t;

    // Target to crossbar response
    // Hit low means the target did not recognise the access
    typedef struct packed {
        logic [63:0] rdata;
        logic        hit;
    } slave_rsp_t;

endpackage
